// File: include/io_defs.svh
// Fixed board I/O map. Widths and address bits are not meant to be overridden
// Peripherals are selected one-hot by address bit; other address bits are ignored
// Both select bits set in one address hits both peripherals at once
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// Bus geometry
`define IO_ADDR_W    32
`define IO_DATA_W    32
`define IO_SEL_W     4     // One enable per byte lane

// One-hot peripheral select bits in the address
`define LED_ADR_BIT  2
`define UART_ADR_BIT 3

// Read data position of the synchronised receive pin
`define RX_RD_BIT    8

// LED port
`define LED_SRC_BIT  31    // Third LED source select, byte lane 3 only
`define LED_COUNT    4

`endif

// File: source/io_pkg.sv
// Shared bus types for the I/O subsystem
// Widths follow the defines header; change them there only
`include "io_defs.svh"

package io_pkg;

   // Bus payload
   typedef logic [`IO_ADDR_W-1:0] io_addr_t;
   typedef logic [`IO_DATA_W-1:0] io_data_t;
   typedef logic [`IO_SEL_W-1:0]  io_sel_t;   // Byte-lane enables

   // Transfer direction
   typedef enum logic {
      IO_READ  = 1'b0,
      IO_WRITE = 1'b1
   } io_op_e;

   // Arbiter grant and last-served record
   typedef enum logic {
      MASTER_A = 1'b0,   // Processor side
      MASTER_B = 1'b1    // Debug side
   } io_master_e;

endpackage

// File: source/io_bus_if.sv
// One granted transfer on the shared I/O bus
// stb is a single-cycle strobe, ack comes back in the same cycle
// No back-pressure; every strobe is acknowledged
`timescale 1ns/100ps

interface io_bus_if import io_pkg::*; ();

   logic     stb;     // Transfer strobe, one cycle
   io_op_e   op;      // Read or write
   io_addr_t addr;
   io_data_t wdata;
   io_sel_t  sel;     // Byte lanes
   logic     ack;     // Same-cycle acknowledge
   io_data_t rdata;   // Valid with ack

   // Arbiter drives the transfer
   modport arb (
      output stb, op, addr, wdata, sel,
      input  ack, rdata
   );

   // Decoder and peripherals receive it
   modport dec (
      input  stb, op, addr, wdata, sel,
      output ack, rdata
   );

endinterface

// File: source/io_bus_arbiter.sv
// Two-master round-robin arbiter, one-deep request register per master
// A master must not strobe again before its ack, or its request is overwritten
// Uncontested strobe-to-ack latency is one cycle
`timescale 1ns/100ps

module io_bus_arbiter import io_pkg::*; (
   input  logic       CLK_I,
   input  logic       rst_n,
   // Master A, processor side
   input  logic       a_stb,
   input  io_op_e     a_op,
   input  io_addr_t   a_addr,
   input  io_data_t   a_wdata,
   input  io_sel_t    a_sel,
   output logic       a_ack,
   output io_data_t   a_rdata,
   // Master B, debug side
   input  logic       b_stb,
   input  io_op_e     b_op,
   input  io_addr_t   b_addr,
   input  io_data_t   b_wdata,
   input  io_sel_t    b_sel,
   output logic       b_ack,
   output io_data_t   b_rdata,
   // Shared bus
   io_bus_if.arb      bus
);

   logic       a_pend, b_pend;   // Request waiting per master
   io_op_e     a_op_q, b_op_q;
   io_addr_t   a_addr_q, b_addr_q;
   io_data_t   a_wdata_q, b_wdata_q;
   io_sel_t    a_sel_q, b_sel_q;
   io_master_e last_q;           // Master served most recently
   io_master_e grant;
   logic       served;

   // Capture requests, payload only
   always_ff @(posedge CLK_I) begin
      if (a_stb) begin
         a_op_q    <= a_op;
         a_addr_q  <= a_addr;
         a_wdata_q <= a_wdata;
         a_sel_q   <= a_sel;
      end
      if (b_stb) begin
         b_op_q    <= b_op;
         b_addr_q  <= b_addr;
         b_wdata_q <= b_wdata;
         b_sel_q   <= b_sel;
      end
   end

   // Pick a pending request
   always_comb begin
      if (a_pend && b_pend)
         grant = (last_q == MASTER_A) ? MASTER_B : MASTER_A;   // Contest, rotate
      else if (b_pend)
         grant = MASTER_B;
      else
         grant = MASTER_A;   // Also the idle default
   end

   // Drive the shared bus from the granted register
   assign bus.stb   = a_pend | b_pend;
   assign bus.op    = (grant == MASTER_B) ? b_op_q    : a_op_q;
   assign bus.addr  = (grant == MASTER_B) ? b_addr_q  : a_addr_q;
   assign bus.wdata = (grant == MASTER_B) ? b_wdata_q : a_wdata_q;
   assign bus.sel   = (grant == MASTER_B) ? b_sel_q   : a_sel_q;

   assign served = bus.stb & bus.ack;   // Transfer completes this cycle

   // Route the response to the granted master only
   assign a_ack   = served & (grant == MASTER_A);
   assign b_ack   = served & (grant == MASTER_B);
   assign a_rdata = a_ack ? bus.rdata : '0;
   assign b_rdata = b_ack ? bus.rdata : '0;

   // Pending flags and round-robin state
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         a_pend <= 1'b0;
         b_pend <= 1'b0;
         last_q <= MASTER_B;   // So A wins the first contest
      end else begin
         a_pend <= a_stb | (a_pend & ~a_ack);   // New strobe beats the clear
         b_pend <= b_stb | (b_pend & ~b_ack);
         if (served)
            last_q <= grant;
      end
   end

endmodule

// File: source/io_addr_decode.sv
// One-hot address decode for the I/O bus, purely combinational
// Only the select bits are decoded, so the map aliases freely
// Both peripherals are strobed when both select bits are set
`timescale 1ns/100ps
`include "io_defs.svh"

module io_addr_decode import io_pkg::*; (
   io_bus_if.dec  bus,
   input  logic   rx_sync,    // Synchronised receive pin from the UART port
   output logic   led_stb,
   output logic   uart_stb
);

   logic uart_rd;

   // Peripheral strobes
   assign led_stb  = bus.stb & bus.addr[`LED_ADR_BIT];
   assign uart_stb = bus.stb & bus.addr[`UART_ADR_BIT];

   // Every transfer completes at once, mapped or not
   assign bus.ack = bus.stb;

   assign uart_rd = uart_stb & (bus.op == IO_READ);

   // Read merge; only the receive pin is readable
   always_comb begin
      bus.rdata             = '0;   // Unmapped reads return zero
      bus.rdata[`RX_RD_BIT] = uart_rd & rx_sync;
   end

endmodule

// File: source/bitbang_uart_port.sv
// Pin-level UART port, framing and baud timing are done in software
// tx resets to idle high; rx is sampled through two flops
`timescale 1ns/100ps

module bitbang_uart_port import io_pkg::*; (
   input  logic   CLK_I,
   input  logic   rst_n,
   input  logic   stb,        // From the decoder
   io_bus_if.dec  bus,        // Only op and wdata are used
   input  logic   rx,         // Asynchronous pin
   output logic   rx_sync,
   output logic   tx
);

   logic rx_meta;   // First synchroniser stage

   // Two-flop synchroniser
   always_ff @(posedge CLK_I) begin
      rx_meta <= rx;
      rx_sync <= rx_meta;   // Two edges from pin to read path
   end

   // Transmit pin register
   always_ff @(posedge CLK_I) begin
      if (!rst_n)
         tx <= 1'b1;   // Line idle
      else if (stb && bus.op == IO_WRITE)
         tx <= bus.wdata[0];
   end

endmodule

// File: source/led_port.sv
// Four-LED port; LED 2 can mirror receive activity instead of bus data
// Mirror mode is changed only by writes with byte lane 3 enabled
// Leaving mirror mode keeps LED 2 as it was until the next write
`timescale 1ns/100ps
`include "io_defs.svh"

module led_port import io_pkg::*; (
   input  logic                  CLK_I,
   input  logic                  rst_n,
   input  logic                  stb,       // From the decoder
   io_bus_if.dec                 bus,       // op, wdata and sel used
   input  logic                  rx_sync,
   output logic [`LED_COUNT-1:0] leds
);

   logic wr;
   logic mirror_q;   // LED 2 shows rx when set

   assign wr = stb & (bus.op == IO_WRITE);

   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         leds     <= '0;   // All off
         mirror_q <= 1'b0;
      end else begin
         if (wr) begin
            // Plain data LEDs, LED 2 handled below
            for (int i = 0; i < `LED_COUNT; i++) begin
               if (i != 2)
                  leds[i] <= bus.wdata[i];
            end
            // Source select lives in the top byte lane
            if (bus.sel[`LED_SRC_BIT / 8])
               mirror_q <= bus.wdata[`LED_SRC_BIT];
         end

         // Shared LED
         if (mirror_q)
            leds[2] <= ~rx_sync;   // Lit while the line is low
         else if (wr)
            leds[2] <= bus.wdata[2];
      end
   end

endmodule

// File: source/io_subsys.sv
// I/O subsystem top: two masters share one bus to the UART pin and LED ports
// Masters use a one-cycle strobe and wait for their single-cycle ack
// rx is asynchronous and synchronised inside; tx and leds are registered
`timescale 1ns/100ps
`include "io_defs.svh"

module io_subsys import io_pkg::*; (
   input  logic                  CLK_I,
   input  logic                  rst_n,
   // Master A
   input  logic                  a_stb,
   input  io_op_e                a_op,
   input  io_addr_t              a_addr,
   input  io_data_t              a_wdata,
   input  io_sel_t               a_sel,
   output logic                  a_ack,
   output io_data_t              a_rdata,
   // Master B
   input  logic                  b_stb,
   input  io_op_e                b_op,
   input  io_addr_t              b_addr,
   input  io_data_t              b_wdata,
   input  io_sel_t               b_sel,
   output logic                  b_ack,
   output io_data_t              b_rdata,
   // Board pins
   input  logic                  rx,
   output logic                  tx,
   output logic [`LED_COUNT-1:0] leds
);

   logic rx_sync;    // Synchronised rx, shared by decoder and LEDs
   logic led_stb;
   logic uart_stb;

   io_bus_if bus ();   // The shared transfer

   io_bus_arbiter u_arbiter (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .a_stb   (a_stb),
      .a_op    (a_op),
      .a_addr  (a_addr),
      .a_wdata (a_wdata),
      .a_sel   (a_sel),
      .a_ack   (a_ack),
      .a_rdata (a_rdata),
      .b_stb   (b_stb),
      .b_op    (b_op),
      .b_addr  (b_addr),
      .b_wdata (b_wdata),
      .b_sel   (b_sel),
      .b_ack   (b_ack),
      .b_rdata (b_rdata),
      .bus     (bus.arb)
   );

   io_addr_decode u_decode (
      .bus      (bus.dec),
      .rx_sync  (rx_sync),
      .led_stb  (led_stb),
      .uart_stb (uart_stb)
   );

   // UART pins, also the owner of the rx synchroniser
   bitbang_uart_port u_uart (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .stb     (uart_stb),
      .bus     (bus.dec),
      .rx      (rx),
      .rx_sync (rx_sync),
      .tx      (tx)
   );

   led_port u_leds (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .stb     (led_stb),
      .bus     (bus.dec),
      .rx_sync (rx_sync),
      .leds    (leds)
   );

endmodule

// File: testbench/tb_clkgen.sv
// Free-running 40 ns clock, first rising edge at 20 ns
// Reset is low for the first 10 rising edges, released just after the 10th
`timescale 1ns/100ps

module tb_clkgen (
   output logic CLK_I,
   output logic rst_n
);

   localparam int half_period  = 20;   // ns
   localparam int reset_cycles = 10;

   initial begin
      CLK_I = 1'b0;
      forever #(half_period) CLK_I = ~CLK_I;
   end

   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge CLK_I);
      rst_n <= 1'b1;   // DUT still sees reset on this edge
   end

endmodule

// File: testbench/tb_io_subsys.sv
// Self-checking testbench for the two-master I/O subsystem
// A cycle model of arbiter, rx synchroniser, tx and LEDs is checked every falling edge
// Inputs change on rising edges only and outputs are sampled on falling edges
// Random stimulus comes from a fixed-seed LFSR, so every run is identical
`timescale 1ns/100ps
`include "io_defs.svh"

module tb_io_subsys import io_pkg::*; ();

   localparam int reset_cycles = 10;
   localparam int n_directed   = 20;    // Transfers in the directed part
   localparam int n_rand       = 100;   // Random rounds of up to two transfers
   localparam int cycle_limit  = 2 * (n_directed + 2 * n_rand) * 3 + reset_cycles;

   typedef struct packed {
      io_op_e   op;
      io_addr_t addr;
      io_data_t wdata;
      io_sel_t  sel;
   } req_t;

   typedef struct packed {
      logic [`LED_COUNT-1:0] leds;
      logic                  mirror;   // LED 2 follows rx
      logic                  tx;
   } model_t;

   logic                  CLK_I;
   logic                  rst_n;
   logic                  a_stb, b_stb;
   io_op_e                a_op, b_op;
   io_addr_t              a_addr, b_addr;
   io_data_t              a_wdata, b_wdata;
   io_sel_t               a_sel, b_sel;
   logic                  a_ack, b_ack;
   io_data_t              a_rdata, b_rdata;
   logic                  rx;
   logic                  tx;
   logic [`LED_COUNT-1:0] leds;

   logic [31:0] lfsr_q;
   io_master_e  last_served;   // Stimulus side view of round robin
   int          reqs;          // Strobes issued
   int          acks;          // Acks seen on the DUT ports
   int          cycles;

   // Reference state owned by the compare process
   model_t      m_state;
   req_t        m_a_req, m_b_req;
   logic        m_a_pend, m_b_pend;
   io_master_e  m_last;
   logic        m_meta, m_sync;   // Two-stage rx delay

   tb_clkgen clkgen (
      .CLK_I (CLK_I),
      .rst_n (rst_n)
   );

   io_subsys UUT (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .a_stb   (a_stb),
      .a_op    (a_op),
      .a_addr  (a_addr),
      .a_wdata (a_wdata),
      .a_sel   (a_sel),
      .a_ack   (a_ack),
      .a_rdata (a_rdata),
      .b_stb   (b_stb),
      .b_op    (b_op),
      .b_addr  (b_addr),
      .b_wdata (b_wdata),
      .b_sel   (b_sel),
      .b_ack   (b_ack),
      .b_rdata (b_rdata),
      .rx      (rx),
      .tx      (tx),
      .leds    (leds)
   );

   // Taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);   // One step per bit
         r      = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic req_t make_req(input io_op_e op, input io_addr_t addr,
                                     input io_data_t wdata, input io_sel_t sel);
      req_t r;
      r.op    = op;
      r.addr  = addr;
      r.wdata = wdata;
      r.sel   = sel;
      return r;
   endfunction

   function automatic req_t rand_req();
      return make_req(io_op_e'(rand_bits(1)), rand_bits(32), rand_bits(32),
                      io_sel_t'(rand_bits(4)));
   endfunction

   // Next LED, mirror and tx state after one clock edge
   function automatic model_t ref_next(input model_t cur, input logic valid,
                                       input req_t r, input logic sync);
      model_t nxt;
      logic   led_wr;
      nxt    = cur;
      led_wr = valid && r.op == IO_WRITE && r.addr[`LED_ADR_BIT];
      if (valid && r.op == IO_WRITE && r.addr[`UART_ADR_BIT])
         nxt.tx = r.wdata[0];
      if (led_wr) begin
         nxt.leds[0] = r.wdata[0];
         nxt.leds[1] = r.wdata[1];
         nxt.leds[3] = r.wdata[3];
         if (r.sel[3])   // Source bit lives in lane 3
            nxt.mirror = r.wdata[`LED_SRC_BIT];
      end
      if (cur.mirror)
         nxt.leds[2] = ~sync;   // Old mode still rules this edge
      else if (led_wr)
         nxt.leds[2] = r.wdata[2];
      return nxt;
   endfunction

   // Only a UART read sees rx and everything else reads zero
   function automatic io_data_t ref_rdata(input req_t r, input logic sync);
      io_data_t d;
      d = '0;
      if (r.op == IO_READ && r.addr[`UART_ADR_BIT])
         d[`RX_RD_BIT] = sync;
      return d;
   endfunction

   task automatic stop_run(input string why);
      if (why.len() > 0)
         $display("Failure at time %0t: %s", $time, why);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_data(input string name, input io_data_t exp, input io_data_t act);
      if (act !== exp) begin
         $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
         stop_run("");
      end
   endtask

   task automatic check_leds(input string name, input logic [`LED_COUNT-1:0] exp,
                             input logic [`LED_COUNT-1:0] act);
      if (act !== exp) begin
         $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
         stop_run("");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
         stop_run("");
      end
   endtask

   // Call right after a rising edge
   task automatic start_req(input io_master_e m, input req_t r);
      if (m == MASTER_A) begin
         a_stb   <= 1'b1;
         a_op    <= r.op;
         a_addr  <= r.addr;
         a_wdata <= r.wdata;
         a_sel   <= r.sel;
      end else begin
         b_stb   <= 1'b1;
         b_op    <= r.op;
         b_addr  <= r.addr;
         b_wdata <= r.wdata;
         b_sel   <= r.sel;
      end
      reqs++;
   endtask

   task automatic set_rx(input logic v);
      @(posedge CLK_I);
      rx <= v;
   endtask

   // One master alone with the ack expected one cycle after the strobe
   task automatic single_xfer(input io_master_e m, input req_t r, output io_data_t rd);
      int lat;
      @(posedge CLK_I);
      start_req(m, r);
      @(posedge CLK_I);
      a_stb <= 1'b0;
      b_stb <= 1'b0;
      lat = 1;
      @(negedge CLK_I);
      while (!((m == MASTER_A) ? a_ack : b_ack)) begin
         @(negedge CLK_I);
         lat++;
      end
      rd          = (m == MASTER_A) ? a_rdata : b_rdata;
      last_served = m;
      if (lat != 1)
         stop_run($sformatf("master %s waited %0d cycles for its ack, not one",
                            m.name(), lat));
   endtask

   // Both masters strobe together and the one not served last must win
   task automatic contest(input req_t ra, input req_t rb);
      io_master_e want;
      io_master_e first;
      logic       got_a, got_b;
      want  = (last_served == MASTER_A) ? MASTER_B : MASTER_A;
      first = want;
      got_a = 1'b0;
      got_b = 1'b0;
      @(posedge CLK_I);
      start_req(MASTER_A, ra);
      start_req(MASTER_B, rb);
      @(posedge CLK_I);
      a_stb <= 1'b0;
      b_stb <= 1'b0;
      while (!(got_a && got_b)) begin
         @(negedge CLK_I);
         if (!got_a && !got_b && (a_ack || b_ack))
            first = a_ack ? MASTER_A : MASTER_B;
         if ((a_ack && got_a) || (b_ack && got_b) || (a_ack && b_ack))
            stop_run("a master got a second ack, or both were acked in one cycle");
         got_a = got_a | a_ack;
         got_b = got_b | b_ack;
      end
      if (first != want)
         stop_run($sformatf("contest served %s first, expected %s",
                            first.name(), want.name()));
      last_served = (first == MASTER_A) ? MASTER_B : MASTER_A;   // Loser goes second
   endtask

   // Cycle model and compare on every falling edge
   always @(negedge CLK_I) begin : compare
      io_master_e g;
      logic       any, exp_a, exp_b;
      req_t       r;
      if (!rst_n) begin
         m_a_pend = 1'b0;
         m_b_pend = 1'b0;
         m_last   = MASTER_B;   // A wins the first contest
         m_state  = '{leds: '0, mirror: 1'b0, tx: 1'b1};
      end else begin
         check_leds("leds", m_state.leds, leds);
         check_bit("tx", m_state.tx, tx);
         if (m_a_pend && m_b_pend)
            g = (m_last == MASTER_A) ? MASTER_B : MASTER_A;
         else
            g = m_b_pend ? MASTER_B : MASTER_A;
         any   = m_a_pend | m_b_pend;
         exp_a = any & (g == MASTER_A);
         exp_b = any & (g == MASTER_B);
         check_bit("a_ack", exp_a, a_ack);
         check_bit("b_ack", exp_b, b_ack);
         r = (g == MASTER_B) ? m_b_req : m_a_req;
         if (exp_a)
            check_data("a_rdata", ref_rdata(r, m_sync), a_rdata);
         if (exp_b)
            check_data("b_rdata", ref_rdata(r, m_sync), b_rdata);
         if (any)
            m_last = g;
         if (a_ack)
            acks++;
         if (b_ack)
            acks++;
         m_state  = ref_next(m_state, any, r, m_sync);
         m_a_pend = a_stb | (m_a_pend & ~exp_a);   // Registered on the next edge
         m_b_pend = b_stb | (m_b_pend & ~exp_b);
         if (a_stb)
            m_a_req = make_req(a_op, a_addr, a_wdata, a_sel);
         if (b_stb)
            m_b_req = make_req(b_op, b_addr, b_wdata, b_sel);
      end
      m_sync = m_meta;
      m_meta = rx;
   end

   always @(posedge CLK_I) begin
      cycles++;
      if (cycles > cycle_limit)
         stop_run($sformatf("timeout after %0d cycles, an ack never came", cycle_limit));
   end

   initial begin : stimulus
      io_data_t rd;
      lfsr_q      = 32'he67e;
      last_served = MASTER_B;
      reqs        = 0;
      acks        = 0;
      cycles      = 0;
      a_stb       = 1'b0;
      a_op        = IO_READ;
      a_addr      = '0;
      a_wdata     = '0;
      a_sel       = '0;
      b_stb       = 1'b0;
      b_op        = IO_READ;
      b_addr      = '0;
      b_wdata     = '0;
      b_sel       = '0;
      rx          = 1'b1;   // Line idle
      m_meta      = 1'b1;
      m_sync      = 1'b1;
      wait (rst_n);
      @(negedge CLK_I);

      // Reset state
      check_bit("tx", 1'b1, tx);
      check_leds("leds", '0, leds);
      check_bit("a_ack", 1'b0, a_ack);
      check_bit("b_ack", 1'b0, b_ack);

      // LED writes from each master
      single_xfer(MASTER_A, make_req(IO_WRITE, 32'h4, 32'h0000_000b, 4'hf), rd);
      @(negedge CLK_I);
      check_leds("leds", 4'b1011, leds);
      single_xfer(MASTER_B, make_req(IO_WRITE, 32'h4, 32'h0000_0004, 4'hf), rd);
      @(negedge CLK_I);
      check_leds("leds", 4'b0100, leds);

      // UART tx and rx
      single_xfer(MASTER_A, make_req(IO_WRITE, 32'h8, 32'h0, 4'h1), rd);
      @(negedge CLK_I);
      check_bit("tx", 1'b0, tx);
      single_xfer(MASTER_B, make_req(IO_WRITE, 32'h8, 32'h1, 4'h1), rd);
      @(negedge CLK_I);
      check_bit("tx", 1'b1, tx);
      set_rx(1'b0);
      single_xfer(MASTER_A, make_req(IO_READ, 32'h8, '0, 4'hf), rd);
      check_data("a_rdata", 32'h0, rd);
      set_rx(1'b1);
      single_xfer(MASTER_B, make_req(IO_READ, 32'h8, '0, 4'hf), rd);
      check_data("b_rdata", 32'h0000_0100, rd);   // rx at bit 8
      single_xfer(MASTER_A, make_req(IO_READ, 32'h4, '0, 4'hf), rd);
      check_data("a_rdata", 32'h0, rd);
      single_xfer(MASTER_A, make_req(IO_READ, 32'h10, '0, 4'hf), rd);   // Unmapped
      check_data("a_rdata", 32'h0, rd);

      // Mirror mode on LED 2
      single_xfer(MASTER_A, make_req(IO_WRITE, 32'h4, 32'h8000_0000, 4'h8), rd);
      set_rx(1'b0);
      repeat (4) @(negedge CLK_I);
      check_bit("leds[2]", 1'b1, leds[2]);
      set_rx(1'b1);
      repeat (4) @(negedge CLK_I);
      check_bit("leds[2]", 1'b0, leds[2]);
      set_rx(1'b0);
      repeat (4) @(negedge CLK_I);
      check_bit("leds[2]", 1'b1, leds[2]);
      single_xfer(MASTER_A, make_req(IO_WRITE, 32'h4, 32'h0, 4'h8), rd);   // Mirror off
      set_rx(1'b1);
      repeat (4) @(negedge CLK_I);
      check_bit("leds[2]", 1'b1, leds[2]);   // No longer follows rx
      single_xfer(MASTER_B, make_req(IO_WRITE, 32'h4, 32'h0, 4'h1), rd);
      @(negedge CLK_I);
      check_leds("leds", 4'b0000, leds);

      // Contests whose winner is set by the transfer before each
      single_xfer(MASTER_A, make_req(IO_READ, 32'h0, '0, 4'h0), rd);
      contest(make_req(IO_WRITE, 32'h4, 32'h5, 4'h1), make_req(IO_READ, 32'h8, '0, 4'hf));
      single_xfer(MASTER_B, make_req(IO_READ, 32'h8, '0, 4'hf), rd);
      contest(make_req(IO_READ, 32'h8, '0, 4'hf), make_req(IO_WRITE, 32'hc, 32'ha, 4'hf));
      single_xfer(MASTER_A, make_req(IO_WRITE, 32'h8, 32'h1, 4'h1), rd);
      contest(make_req(IO_WRITE, 32'h4, 32'h3, 4'hf), make_req(IO_READ, 32'hc, '0, 4'hf));

      // Random mix checked cycle by cycle
      for (int n = 0; n < n_rand; n++) begin
         if (rand_bits(2) == 0)
            set_rx(rand_bits(1) != 0);
         case (rand_bits(2))
            2'd0, 2'd1: single_xfer(MASTER_A, rand_req(), rd);
            2'd2:       single_xfer(MASTER_B, rand_req(), rd);
            default:    contest(rand_req(), rand_req());
         endcase
      end

      repeat (2) @(negedge CLK_I);
      if (acks != reqs)
         stop_run($sformatf("%0d strobes issued but %0d acks seen", reqs, acks));
      else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

// File: io_subsys.f
+incdir+include
source/io_pkg.sv
source/io_bus_if.sv
source/io_bus_arbiter.sv
source/io_addr_decode.sv
source/bitbang_uart_port.sv
source/led_port.sv
source/io_subsys.sv
testbench/tb_clkgen.sv
testbench/tb_io_subsys.sv
